/* src/capPkg.sv */
package capPkg;

    //////////////////////////////////////////////////
    // Widths.
    //////////////////////////////////////////////////
    localparam int DATA_W = 8;    // Sensor byte.
    localparam int WORD_W = 16;   // Line buffer word.
    localparam int ADDR_W = 14;   // Line buffer address.

    //////////////////////////////////////////////////
    // Sensor header bytes.
    //////////////////////////////////////////////////
    // Every tag follows the prefix FF 00 00.
    localparam logic [DATA_W-1:0] SYNC_B0 = 8'hFF;
    localparam logic [DATA_W-1:0] SYNC_B1 = 8'h00;
    localparam logic [DATA_W-1:0] SYNC_B2 = 8'h00;

    // Frame opens with three tags in this order.
    localparam logic [DATA_W-1:0] TAG_FRAME1 = 8'hB6;
    localparam logic [DATA_W-1:0] TAG_FRAME2 = 8'hAB;
    localparam logic [DATA_W-1:0] TAG_FRAME3 = 8'h9D;

    localparam logic [DATA_W-1:0] TAG_LINE = 8'h80;   // Opens each line.

    //////////////////////////////////////////////////
    // Stage structs.
    //////////////////////////////////////////////////
    typedef struct packed {
        logic              valid;   // One-cycle strobe.
        logic [DATA_W-1:0] data;
    } sensorByte_s;

    typedef struct packed {
        logic              valid;
        logic [DATA_W-1:0] data;
        logic              lastOfLine;    // Final byte of a line.
        logic              lastOfFrame;   // Final byte of the last line.
    } payloadByte_s;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;          // First byte high.
        logic              lastOfLine;
        logic              lastOfFrame;
    } pixelWord_s;

    // Write port of the two single-port line buffers.
    typedef struct packed {
        logic              en;
        logic              bank;          // Which buffer, 0 or 1.
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
    } ramWrite_s;

endpackage

/* src/pixelSampler.sv */
`timescale 1ns/10ps

module pixelSampler (
    input  logic                        iClk,
    input  logic                        iRst_N,
    input  logic                        irPclk,
    input  logic [capPkg::DATA_W-1:0]   irData,
    output capPkg::sensorByte_s         sampled
);

    logic [2:0]                  pclkSync;    // [0],[1] synchronizer, [2] history.
    logic [capPkg::DATA_W-1:0]   dataSync0;   // First sync stage of the bus.
    logic [capPkg::DATA_W-1:0]   dataSync1;   // Second sync stage.
    logic                        pclkRise;
    logic                        riseSeen;    // Edge found, byte held.
    logic [capPkg::DATA_W-1:0]   byteHold;
    logic                        byteValid;
    logic [capPkg::DATA_W-1:0]   byteData;

    // Low before, high now.
    assign pclkRise = pclkSync[1] & ~pclkSync[2];

    //////////////////////////////////////////////////
    // Pixel clock synchronizer and edge flag.
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            pclkSync  <= '0;
            riseSeen  <= 1'b0;
            byteValid <= 1'b0;
        end else begin
            pclkSync  <= {pclkSync[1:0], irPclk};
            riseSeen  <= pclkRise;
            byteValid <= riseSeen;   // One strobe per rising edge.
        end
    end

    // Data path carries no reset.
    always_ff @(posedge iClk) begin
        dataSync0 <= irData;
        dataSync1 <= dataSync0;
        if (pclkRise) begin
            byteHold <= dataSync1;   // Bus as seen at the first high sample.
        end
        if (riseSeen) begin
            byteData <= byteHold;
        end
    end

    assign sampled = '{valid: byteValid, data: byteData};

endmodule

/* src/syncDetector.sv */
`timescale 1ns/10ps

module syncDetector #(
    parameter int BYTES_PER_LINE  = 1024,   // Must be even.
    parameter int LINES_PER_FRAME = 192
) (
    input  logic                    iClk,
    input  logic                    iRst_N,
    input  logic                    ramInitDone,
    input  capPkg::sensorByte_s     sampled,
    output capPkg::payloadByte_s    payload,
    output logic                    frameStart
);

    localparam int BCNT_W = $clog2(BYTES_PER_LINE);
    localparam int LCNT_W = $clog2(LINES_PER_FRAME);

    typedef enum logic [2:0] {
        sWaitInit,    // Line buffer owner not ready yet.
        sFrameTag1,
        sFrameTag2,
        sFrameTag3,
        sLineTag,
        sPayload
    } state_e;

    state_e                      state;
    logic [capPkg::DATA_W-1:0]   hist0;       // Newest byte.
    logic [capPkg::DATA_W-1:0]   hist1;
    logic [capPkg::DATA_W-1:0]   hist2;       // Oldest byte.
    logic                        prefixOk;
    logic                        tagSeen;     // Byte arrives right after FF 00 00.
    logic [BCNT_W-1:0]           byteCnt;
    logic [LCNT_W-1:0]           lineCnt;
    logic                        lastByte;
    logic                        lastLine;
    logic                        outValid;
    logic [capPkg::DATA_W-1:0]   outData;
    logic                        outLastLine;
    logic                        outLastFrame;

    assign prefixOk = (hist2 == capPkg::SYNC_B0) &&
                      (hist1 == capPkg::SYNC_B1) &&
                      (hist0 == capPkg::SYNC_B2);
    assign tagSeen  = sampled.valid && prefixOk;

    assign lastByte = (byteCnt == BCNT_W'(BYTES_PER_LINE - 1));
    assign lastLine = (lineCnt == LCNT_W'(LINES_PER_FRAME - 1));

    //////////////////////////////////////////////////
    // Header search FSM and line counters.
    //////////////////////////////////////////////////
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            state      <= sWaitInit;
            hist0      <= '0;
            hist1      <= '0;
            hist2      <= '0;
            byteCnt    <= '0;
            lineCnt    <= '0;
            outValid   <= 1'b0;
            frameStart <= 1'b0;
        end else begin
            outValid   <= 1'b0;   // Strobes by default.
            frameStart <= 1'b0;

            if (sampled.valid) begin
                hist2 <= hist1;
                hist1 <= hist0;
                hist0 <= sampled.data;
            end

            case (state)
                sWaitInit: begin
                    if (ramInitDone) begin
                        state <= sFrameTag1;
                    end
                end
                // A wrong byte keeps the search where it is.
                sFrameTag1: begin
                    if (tagSeen && sampled.data == capPkg::TAG_FRAME1) begin
                        state <= sFrameTag2;
                    end
                end
                sFrameTag2: begin
                    if (tagSeen && sampled.data == capPkg::TAG_FRAME2) begin
                        state <= sFrameTag3;
                    end
                end
                sFrameTag3: begin
                    if (tagSeen && sampled.data == capPkg::TAG_FRAME3) begin
                        state      <= sLineTag;
                        frameStart <= 1'b1;   // Frame header complete.
                        lineCnt    <= '0;
                    end
                end
                sLineTag: begin
                    if (tagSeen && sampled.data == capPkg::TAG_LINE) begin
                        state   <= sPayload;
                        byteCnt <= '0;
                    end
                end
                sPayload: begin
                    if (sampled.valid) begin
                        outValid <= 1'b1;     // Forward every payload byte.
                        if (lastByte) begin
                            byteCnt <= '0;
                            if (lastLine) begin
                                lineCnt <= '0;
                                state   <= sFrameTag1;   // Next frame needs a full header.
                            end else begin
                                lineCnt <= lineCnt + 1'b1;
                                state   <= sLineTag;
                            end
                        end else begin
                            byteCnt <= byteCnt + 1'b1;
                        end
                    end
                end
                default: state <= sWaitInit;
            endcase
        end
    end

    // Payload byte and its markers.
    always_ff @(posedge iClk) begin
        if (sampled.valid) begin
            outData      <= sampled.data;
            outLastLine  <= lastByte;
            outLastFrame <= lastByte && lastLine;
        end
    end

    assign payload = '{valid:       outValid,
                       data:        outData,
                       lastOfLine:  outLastLine,
                       lastOfFrame: outLastFrame};

endmodule

/* src/wordPacker.sv */
`timescale 1ns/10ps

module wordPacker (
    input  logic                    iClk,
    input  logic                    iRst_N,
    input  capPkg::payloadByte_s    payload,
    output capPkg::pixelWord_s      word
);

    logic                        haveHigh;   // Even byte waiting for its pair.
    logic [capPkg::DATA_W-1:0]   highByte;
    logic                        wordValid;
    logic [capPkg::WORD_W-1:0]   wordData;
    logic                        wordLastLine;
    logic                        wordLastFrame;

    //////////////////////////////////////////////////
    // Pair tracking.
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            haveHigh  <= 1'b0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= 1'b0;
            if (payload.valid) begin
                if (haveHigh) begin
                    haveHigh  <= 1'b0;
                    wordValid <= 1'b1;   // Odd byte closes the pair.
                end else begin
                    haveHigh <= ~payload.lastOfLine;   // Lone byte at line end is dropped.
                end
            end
        end
    end

    // Word assembly, first byte high.
    always_ff @(posedge iClk) begin
        if (payload.valid) begin
            if (!haveHigh) begin
                highByte <= payload.data;
            end else begin
                wordData      <= {highByte, payload.data};
                wordLastLine  <= payload.lastOfLine;
                wordLastFrame <= payload.lastOfFrame;
            end
        end
    end

    assign word = '{valid:       wordValid,
                    data:        wordData,
                    lastOfLine:  wordLastLine,
                    lastOfFrame: wordLastFrame};

endmodule

/* src/lineWriter.sv */
`timescale 1ns/10ps

module lineWriter (
    input  logic                iClk,
    input  logic                iRst_N,
    input  capPkg::pixelWord_s  word,
    output capPkg::ramWrite_s   ramWr,
    output logic                lineDone,
    output logic                frameDone
);

    logic [capPkg::ADDR_W-1:0]   addrCnt;    // Next free address in this line.
    logic                        bankSel;    // Buffer taking the current line.
    logic                        wrEn;
    logic                        wrBank;
    logic [capPkg::ADDR_W-1:0]   wrAddr;
    logic [capPkg::WORD_W-1:0]   wrData;
    logic                        frameLast;  // Last write of the frame is going out.

    //////////////////////////////////////////////////
    // Address, bank and done pulses.
    //////////////////////////////////////////////////
    always_ff @(posedge iClk or negedge iRst_N) begin
        if (!iRst_N) begin
            addrCnt   <= '0;
            bankSel   <= 1'b0;   // Buffer 0 first.
            wrEn      <= 1'b0;
            wrBank    <= 1'b0;
            wrAddr    <= '0;
            lineDone  <= 1'b0;
            frameLast <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            wrEn      <= word.valid;                       // One write per word.
            lineDone  <= word.valid && word.lastOfLine;    // Same cycle as the write.
            frameLast <= word.valid && word.lastOfFrame;
            frameDone <= frameLast;                        // One cycle after the write.

            if (word.valid) begin
                wrBank <= bankSel;
                wrAddr <= addrCnt;
                if (word.lastOfLine) begin
                    addrCnt <= '0;
                    bankSel <= ~bankSel;   // Swap buffers for the next line.
                end else begin
                    addrCnt <= addrCnt + 1'b1;
                end
            end
        end
    end

    // Write data.
    always_ff @(posedge iClk) begin
        if (word.valid) begin
            wrData <= word.data;
        end
    end

    assign ramWr = '{en:   wrEn,
                     bank: wrBank,
                     addr: wrAddr,
                     data: wrData};

endmodule

/* src/irCapture.sv */
`timescale 1ns/10ps

module irCapture #(
    parameter int BYTES_PER_LINE  = 1024,   // Must be even.
    parameter int LINES_PER_FRAME = 192
) (
    input  logic                        iClk,
    input  logic                        iRst_N,
    input  logic                        irPclk,
    input  logic [capPkg::DATA_W-1:0]   irData,
    input  logic                        ramInitDone,   // Line buffer owner is ready.
    output capPkg::ramWrite_s           ramWr,
    output logic                        capFrameStart,
    output logic                        capLineDone,
    output logic                        capFrameDone
);

    capPkg::sensorByte_s    sampledByte;
    capPkg::payloadByte_s   payloadByte;
    capPkg::pixelWord_s     pixelWord;

    //////////////////////////////////////////////////
    // Sampler, header search, packer, writer.
    pixelSampler pixelSampler_i (
        .iClk    (iClk),
        .iRst_N  (iRst_N),
        .irPclk  (irPclk),
        .irData  (irData),
        .sampled (sampledByte)
    );

    syncDetector #(
        .BYTES_PER_LINE  (BYTES_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) syncDetector_i (
        .iClk        (iClk),
        .iRst_N      (iRst_N),
        .ramInitDone (ramInitDone),
        .sampled     (sampledByte),
        .payload     (payloadByte),
        .frameStart  (capFrameStart)
    );

    wordPacker wordPacker_i (
        .iClk    (iClk),
        .iRst_N  (iRst_N),
        .payload (payloadByte),
        .word    (pixelWord)
    );

    lineWriter lineWriter_i (
        .iClk      (iClk),
        .iRst_N    (iRst_N),
        .word      (pixelWord),
        .ramWr     (ramWr),
        .lineDone  (capLineDone),    // 6 cycles after the last byte's pixel clock edge.
        .frameDone (capFrameDone)
    );

endmodule

/* test/tbClock.sv */
`timescale 1ns/10ps

module tbClock (
    output logic iClk,
    output logic iRst_N
);

    localparam int RESET_CYCLES = 16;

    initial begin
        iClk = 1'b0;
        forever #2 iClk = ~iClk;   // 4 ns period.
    end

    // Reset low for RESET_CYCLES edges, released just after an edge.
    task automatic applyReset();
        iRst_N = 1'b0;
        repeat (RESET_CYCLES) @(posedge iClk);
        #1 iRst_N = 1'b1;
    endtask

    initial applyReset();   // Power-on reset.

endmodule

/* test/capMonitor.sv */
`timescale 1ns/10ps

module capMonitor (
    input  logic                iClk,
    input  capPkg::ramWrite_s   ramWr,
    input  logic                capFrameStart,
    input  logic                capLineDone,
    input  logic                capFrameDone
);

    typedef enum logic [1:0] {
        evWrite,
        evFrameStart,
        evFrameDone
    } evKind_e;

    typedef struct packed {
        evKind_e             kind;
        logic                lineDone;   // Write closes its line.
        capPkg::ramWrite_s   wr;
    } capEvent_s;

    capEvent_s   expQ[$];          // Expected events, oldest first.
    int          errCount   = 0;
    int          eventCount = 0;   // Events matched against the queue.

    function automatic int pending();
        return expQ.size();
    endfunction

    task automatic flush();
        expQ.delete();
    endtask

    function automatic string kindName(input evKind_e k);
        case (k)
            evWrite:      return "write";
            evFrameStart: return "frame start";
            default:      return "frame done";
        endcase
    endfunction

    task automatic expectWrite(input logic bank, input logic [capPkg::ADDR_W-1:0] addr,
                               input logic [capPkg::WORD_W-1:0] data, input logic last);
        capEvent_s e;
        e          = '0;
        e.kind     = evWrite;
        e.lineDone = last;
        e.wr.en    = 1'b1;
        e.wr.bank  = bank;
        e.wr.addr  = addr;
        e.wr.data  = data;
        expQ.push_back(e);
    endtask

    task automatic expectPulse(input logic isDone);
        capEvent_s e;
        e      = '0;
        e.kind = isDone ? evFrameDone : evFrameStart;
        expQ.push_back(e);
    endtask

    task automatic compareField(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        if (exp !== got) begin
            $display("CHECK FAILED %s exp %h got %h at %0t ns", name, exp, got, $time);
            errCount++;
        end
    endtask

    //////////////////////////////////////////////////
    // Compare one DUT event against the queue head.
    task automatic observe(input evKind_e kind);
        capEvent_s e;
        if (expQ.size() == 0) begin
            $display("unexpected %s at %0t ns, none was expected", kindName(kind), $time);
            errCount++;
        end else begin
            e = expQ.pop_front();
            eventCount++;
            if (e.kind != kind) begin
                $display("expected a %s but saw a %s at %0t ns",
                         kindName(e.kind), kindName(kind), $time);
                errCount++;
            end else if (kind == evWrite) begin
                compareField("ramWr.en", e.wr.en, ramWr.en);
                compareField("ramWr.bank", e.wr.bank, ramWr.bank);
                compareField("ramWr.addr", e.wr.addr, ramWr.addr);
                compareField("ramWr.data", e.wr.data, ramWr.data);
                compareField("capLineDone", e.lineDone, capLineDone);
            end
        end
    endtask

    // Outputs during reset.
    task automatic checkIdle();
        compareField("ramWr.en", 0, ramWr.en);
        compareField("ramWr.bank", 0, ramWr.bank);
        compareField("capFrameStart", 0, capFrameStart);
        compareField("capLineDone", 0, capLineDone);
        compareField("capFrameDone", 0, capFrameDone);
    endtask

    // Falling edge, halfway between DUT updates.
    always @(negedge iClk) begin
        if (capFrameStart) observe(evFrameStart);
        if (ramWr.en || capLineDone) observe(evWrite);   // Lone lineDone shows as en error.
        if (capFrameDone) observe(evFrameDone);
    end

endmodule

/* test/capChk.sv */
`timescale 1ns/10ps

module capChk (
    input  logic iClk,
    input  logic iRst_N,
    input  logic wrEn,
    input  logic lineDone,
    input  logic frameDone
);

    int failCount = 0;   // Failed assertions so far.

    // Words come at least 8 cycles apart.
    enSingle: assert property (@(posedge iClk) disable iff (!iRst_N) wrEn |=> !wrEn)
        else begin
            $error("write enable held for two cycles");
            failCount++;
        end

    lineWithWrite: assert property (@(posedge iClk) disable iff (!iRst_N) lineDone |-> wrEn)
        else begin
            $error("line done without a write");
            failCount++;
        end

    // Frame done trails the last write by one cycle.
    frameAfterWrite: assert property (@(posedge iClk) disable iff (!iRst_N)
                                      frameDone |-> !wrEn)
        else begin
            $error("frame done together with a write");
            failCount++;
        end

endmodule

bind lineWriter capChk capChk_i (
    .iClk      (iClk),
    .iRst_N    (iRst_N),
    .wrEn      (wrEn),
    .lineDone  (lineDone),
    .frameDone (frameDone)
);

/* test/tbIrCapture.sv */
`timescale 1ns/10ps

module tbIrCapture;

    localparam int BYTES_PER_LINE  = 16;
    localparam int LINES_PER_FRAME = 3;
    localparam int DRAIN_LIMIT     = 4000;   // Cycles allowed for pending events.

    logic                        iClk;
    logic                        iRst_N;
    logic                        irPclk;
    logic [capPkg::DATA_W-1:0]   irData;
    logic                        ramInitDone;
    capPkg::ramWrite_s           ramWr;
    logic                        capFrameStart;
    logic                        capLineDone;
    logic                        capFrameDone;

    integer                      seed;
    logic                        modelBank;      // Bank of the next expected line.
    int                          timeoutCount;
    int                          testsRun;
    int                          testsFailed;
    logic [capPkg::DATA_W-1:0]   lineBuf [BYTES_PER_LINE];

    tbClock clockGen_i (.iClk(iClk), .iRst_N(iRst_N));

    irCapture #(
        .BYTES_PER_LINE  (BYTES_PER_LINE),
        .LINES_PER_FRAME (LINES_PER_FRAME)
    ) irCapture_i (
        .iClk          (iClk),
        .iRst_N        (iRst_N),
        .irPclk        (irPclk),
        .irData        (irData),
        .ramInitDone   (ramInitDone),
        .ramWr         (ramWr),
        .capFrameStart (capFrameStart),
        .capLineDone   (capLineDone),
        .capFrameDone  (capFrameDone)
    );

    capMonitor capMonitor_i (
        .iClk          (iClk),
        .ramWr         (ramWr),
        .capFrameStart (capFrameStart),
        .capLineDone   (capLineDone),
        .capFrameDone  (capFrameDone)
    );

    function automatic logic [7:0] randByte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // No FF, so filler never forms a sync prefix.
    function automatic logic [7:0] fillerByte();
        logic [7:0] b;
        b = randByte();
        return (b == 8'hFF) ? 8'h5A : b;
    endfunction

    function automatic int errorTotal();
        return capMonitor_i.errCount + timeoutCount + irCapture_i.lineWriter_i.capChk_i.failCount;
    endfunction

    //////////////////////////////////////////////////
    // Sensor side.
    //////////////////////////////////////////////////
    // One pixel clock period, 4 cycles low then 4 high.
    task automatic sendByte(input logic [7:0] b);
        @(posedge iClk);
        #1;
        irPclk = 1'b0;   // Data moves with the falling edge.
        irData = b;
        repeat (4) @(posedge iClk);
        #1;
        irPclk = 1'b1;
        repeat (3) @(posedge iClk);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge iClk);
        #1;
        irPclk = 1'b0;
    endtask

    task automatic sendHeader(input logic [7:0] b0, b1, b2, tag);
        sendByte(b0);
        sendByte(b1);
        sendByte(b2);
        sendByte(tag);
    endtask

    task automatic sendFrameHeader(input logic expectIt);
        if (expectIt) capMonitor_i.expectPulse(1'b0);   // frameStart.
        sendHeader(8'hFF, 8'h00, 8'h00, 8'hB6);
        sendHeader(8'hFF, 8'h00, 8'h00, 8'hAB);
        sendHeader(8'hFF, 8'h00, 8'h00, 8'h9D);
    endtask

    // Line header and nBytes payload; model pushes the writes first.
    task automatic sendLine(input logic expectIt, input int nBytes, input logic lastLine);
        for (int i = 0; i < nBytes; i++) begin
            lineBuf[i] = expectIt ? randByte() : fillerByte();
        end
        if (expectIt) begin
            for (int i = 0; i < nBytes / 2; i++) begin
                capMonitor_i.expectWrite(modelBank, capPkg::ADDR_W'(i),
                                         {lineBuf[2*i], lineBuf[2*i+1]},
                                         nBytes == BYTES_PER_LINE && i == nBytes / 2 - 1);
            end
            if (lastLine) capMonitor_i.expectPulse(1'b1);     // frameDone.
            if (nBytes == BYTES_PER_LINE) modelBank = ~modelBank;
        end
        sendHeader(8'hFF, 8'h00, 8'h00, 8'h80);
        for (int i = 0; i < nBytes; i++) begin
            sendByte(lineBuf[i]);
        end
    endtask

    task automatic sendFrame(input logic expectIt);
        sendFrameHeader(expectIt);
        for (int l = 0; l < LINES_PER_FRAME; l++) begin
            sendLine(expectIt, BYTES_PER_LINE, l == LINES_PER_FRAME - 1);
        end
    endtask

    //////////////////////////////////////////////////
    // Test bookkeeping.
    //////////////////////////////////////////////////
    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (capMonitor_i.pending() != 0 && cycles < DRAIN_LIMIT) begin
            @(posedge iClk);
            cycles++;
        end
        if (capMonitor_i.pending() != 0) begin
            $display("timeout: %0d expected DUT events never appeared", capMonitor_i.pending());
            timeoutCount++;
            capMonitor_i.flush();
        end
        idle(1);
    endtask

    task automatic finishTest(input string name, input int errBefore);
        int errs;
        waitDrain();
        idle(24);                    // Room for stray events.
        errs = errorTotal() - errBefore;
        testsRun++;
        if (errs != 0) testsFailed++;
        $display("test %0d %s: %0d error(s)", testsRun, name, errs);
    endtask

    initial begin
        int cycles;
        int errBefore;
        irPclk       = 1'b0;
        irData       = '0;
        ramInitDone  = 1'b0;
        seed         = 32'h2109_0755;
        modelBank    = 1'b0;
        timeoutCount = 0;
        testsRun     = 0;
        testsFailed  = 0;
        cycles       = 0;
        while (iRst_N !== 1'b1 && cycles < 100) begin
            @(posedge iClk);
            cycles++;
        end
        if (iRst_N !== 1'b1) begin
            $display("reset was never released");
            timeoutCount++;
        end
        idle(4);

        errBefore = errorTotal();
        sendFrame(1'b0);             // Owner not ready, nothing expected.
        idle(16);
        ramInitDone = 1'b1;
        sendFrame(1'b1);
        finishTest("init gate", errBefore);

        errBefore = errorTotal();
        repeat (24) sendByte(fillerByte());
        sendHeader(8'hFF, 8'h01, 8'h00, 8'hB6);   // Damaged prefixes.
        sendHeader(8'hFE, 8'h00, 8'h00, 8'hB6);
        sendHeader(8'hFF, 8'h00, 8'h80, 8'hB6);
        sendHeader(8'hFF, 8'h00, 8'h00, 8'h9D);   // Tags out of order.
        sendHeader(8'hFF, 8'h00, 8'h00, 8'hAB);
        repeat (8) sendByte(fillerByte());
        sendFrame(1'b1);
        finishTest("frame header search", errBefore);

        errBefore = errorTotal();
        sendFrame(1'b1);
        finishTest("line address and data", errBefore);

        errBefore = errorTotal();
        sendFrame(1'b1);             // Banks keep alternating across frames.
        sendFrame(1'b1);
        finishTest("bank alternation", errBefore);

        errBefore = errorTotal();
        sendFrame(1'b1);
        sendLine(1'b0, BYTES_PER_LINE, 1'b0);   // Line header with no frame header.
        finishTest("frame done and orphan line", errBefore);

        errBefore = errorTotal();
        sendFrameHeader(1'b1);
        sendLine(1'b1, BYTES_PER_LINE, 1'b0);   // Full line leaves bank 1 selected.
        sendLine(1'b1, 6, 1'b0);     // Three words, then reset mid-line.
        idle(16);
        waitDrain();
        ramInitDone = 1'b0;
        fork
            clockGen_i.applyReset();
            begin
                repeat (8) @(posedge iClk);
                #1;
                capMonitor_i.checkIdle();
            end
        join
        modelBank = 1'b0;
        sendFrame(1'b0);             // Owner not ready again.
        idle(16);
        ramInitDone = 1'b1;
        sendLine(1'b0, BYTES_PER_LINE, 1'b0);
        sendFrame(1'b1);
        finishTest("reset mid-line", errBefore);

        $display("%0d tests run, %0d failed, %0d events checked, %0d errors",
                 testsRun, testsFailed, capMonitor_i.eventCount, errorTotal());
        if (testsFailed == 0 && errorTotal() == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sim.f */
src/capPkg.sv
src/pixelSampler.sv
src/syncDetector.sv
src/wordPacker.sv
src/lineWriter.sv
src/irCapture.sv
test/tbClock.sv
test/capMonitor.sv
test/capChk.sv
test/tbIrCapture.sv
